//--- hw/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

    // bus widths
    localparam int ADDR_W = 30;
    localparam int DATA_W = 32;
    localparam int SEL_W = 4;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [SEL_W-1:0] sel_t;

    // page field sits in the top word-address bits
    localparam int PAGE_W = 9;
    localparam logic [PAGE_W-1:0] MEM_PAGE = 9'd0;
    localparam logic [PAGE_W-1:0] SYS_PAGE = 9'd1;
    localparam addr_t SWLED_ADDR = 30'h400004;

    typedef enum logic [1:0] {
        DEV_MEM,
        DEV_SYS,
        DEV_SWLED,
        DEV_NONE
    } dev_e;

    // system register offsets in the low address bits
    typedef enum logic [3:0] {
        REG_ID       = 4'd0,
        REG_SCRATCH  = 4'd1,
        REG_ERR_ADDR = 4'd2,
        REG_POWER    = 4'd3,
        REG_IRQ      = 4'd4
    } sys_reg_e;

    localparam data_t SYS_ID = 32'h20191028;

endpackage

`default_nettype wire

//--- hw/wb_pri_arbiter.sv
`default_nettype none

module wb_pri_arbiter (
    input  wire logic               i_clk,
    input  wire logic               i_reset,
    // master a has priority
    input  wire logic               i_a_cyc,
    input  wire logic               i_a_stb,
    input  wire logic               i_a_we,
    input  wire soc_bus_pkg::addr_t i_a_addr,
    input  wire soc_bus_pkg::data_t i_a_data,
    input  wire soc_bus_pkg::sel_t  i_a_sel,
    output logic                    o_a_ack,
    output logic                    o_a_stall,
    output logic                    o_a_err,
    // master b
    input  wire logic               i_b_cyc,
    input  wire logic               i_b_stb,
    input  wire logic               i_b_we,
    input  wire soc_bus_pkg::addr_t i_b_addr,
    input  wire soc_bus_pkg::data_t i_b_data,
    input  wire soc_bus_pkg::sel_t  i_b_sel,
    output logic                    o_b_ack,
    output logic                    o_b_stall,
    output logic                    o_b_err,
    // merged bus toward the decoder
    output logic                    o_cyc,
    output logic                    o_stb,
    output logic                    o_we,
    output soc_bus_pkg::addr_t      o_addr,
    output soc_bus_pkg::data_t      o_data,
    output soc_bus_pkg::sel_t       o_sel,
    input  wire logic               i_ack,
    input  wire logic               i_err
);

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_A,
        OWN_B
    } owner_e;

    owner_e owner_q;
    owner_e grant;

    // current owner holds while its cyc stays up and a wins otherwise
    always_comb begin
        grant = OWN_NONE;
        if (owner_q == OWN_A && i_a_cyc) begin
            grant = OWN_A;
        end else if (owner_q == OWN_B && i_b_cyc) begin
            grant = OWN_B;
        end else if (i_a_cyc) begin
            grant = OWN_A;
        end else if (i_b_cyc) begin
            grant = OWN_B;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            owner_q <= OWN_NONE;
        end else begin
            owner_q <= grant;
        end
    end

    // request mux
    assign o_cyc  = (grant == OWN_A) ? i_a_cyc : (grant == OWN_B) ? i_b_cyc : 1'b0;
    assign o_stb  = (grant == OWN_A) ? (i_a_cyc && i_a_stb)
                  : (grant == OWN_B) ? (i_b_cyc && i_b_stb) : 1'b0;
    assign o_we   = (grant == OWN_B) ? i_b_we : i_a_we;
    assign o_addr = (grant == OWN_B) ? i_b_addr : i_a_addr;
    assign o_data = (grant == OWN_B) ? i_b_data : i_a_data;
    assign o_sel  = (grant == OWN_B) ? i_b_sel : i_a_sel;

    // responses go only to the owner while the other one waits
    assign o_a_ack   = (grant == OWN_A) && i_ack;
    assign o_a_err   = (grant == OWN_A) && i_err;
    assign o_a_stall = i_a_stb && (grant != OWN_A);
    assign o_b_ack   = (grant == OWN_B) && i_ack;
    assign o_b_err   = (grant == OWN_B) && i_err;
    assign o_b_stall = i_b_stb && (grant != OWN_B);

endmodule

`default_nettype wire

//--- hw/bus_decoder.sv
`default_nettype none

module bus_decoder (
    input  wire logic               i_clk,
    input  wire logic               i_reset,
    input  wire logic               i_stb,
    input  wire soc_bus_pkg::addr_t i_addr,
    output logic                    o_mem_stb,
    output logic                    o_sys_stb,
    output logic                    o_swled_stb,
    input  wire logic               i_mem_ack,
    input  wire soc_bus_pkg::data_t i_mem_data,
    input  wire logic               i_sys_ack,
    input  wire soc_bus_pkg::data_t i_sys_data,
    input  wire logic               i_swled_ack,
    input  wire soc_bus_pkg::data_t i_swled_data,
    output logic                    o_ack,
    output logic                    o_err,
    output soc_bus_pkg::data_t      o_data
);

    import soc_bus_pkg::*;

    dev_e dev;
    logic [PAGE_W-1:0] page;

    assign page = i_addr[ADDR_W-1 -: PAGE_W];

    // 0x400000 is unmapped and falls through to none
    always_comb begin
        if (page == MEM_PAGE) begin
            dev = DEV_MEM;
        end else if (page == SYS_PAGE) begin
            dev = DEV_SYS;
        end else if (i_addr == SWLED_ADDR) begin
            dev = DEV_SWLED;
        end else begin
            dev = DEV_NONE;
        end
    end

    assign o_mem_stb   = i_stb && (dev == DEV_MEM);
    assign o_sys_stb   = i_stb && (dev == DEV_SYS);
    assign o_swled_stb = i_stb && (dev == DEV_SWLED);

    // one registered stage for the merged response
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ack  <= 1'b0;
            o_err  <= 1'b0;
            o_data <= '0;
        end else begin
            o_ack <= i_mem_ack || i_sys_ack || i_swled_ack;
            o_err <= i_stb && (dev == DEV_NONE);
            if (i_sys_ack) begin
                o_data <= i_sys_data;
            end else if (i_mem_ack) begin
                o_data <= i_mem_data;
            end else if (i_swled_ack) begin
                o_data <= i_swled_data;
            end else begin
                o_data <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/sys_regs.sv
`default_nettype none

module sys_regs (
    input  wire logic               i_clk,
    input  wire logic               i_reset,
    input  wire logic               i_stb,
    input  wire logic               i_we,
    input  wire soc_bus_pkg::addr_t i_addr,
    input  wire soc_bus_pkg::data_t i_data,
    input  wire logic               i_bus_err,
    output logic                    o_ack,
    output soc_bus_pkg::data_t      o_data,
    output logic                    o_interrupt
);

    import soc_bus_pkg::*;

    sys_reg_e reg_sel;
    addr_t    addr_q;
    addr_t    err_addr;
    data_t    scratch;
    data_t    power_cnt;

    assign reg_sel = sys_reg_e'(i_addr[3:0]);

    // the error pulse lags the strobe by one cycle
    always_ff @(posedge i_clk) begin
        addr_q <= i_addr;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ack       <= 1'b0;
            o_interrupt <= 1'b0;
            scratch     <= '0;
            err_addr    <= '0;
            power_cnt   <= '0;
        end else begin
            o_ack <= i_stb;
            if (i_stb && i_we) begin
                case (reg_sel)
                    REG_SCRATCH: scratch <= i_data;
                    REG_IRQ:     o_interrupt <= i_data[0];
                    default:     ;
                endcase
            end
            if (i_bus_err) begin
                err_addr <= addr_q;
            end
            // top bit sticks while the low bits keep counting
            power_cnt[DATA_W-2:0] <= power_cnt[DATA_W-2:0] + 1'b1;
            power_cnt[DATA_W-1]   <= power_cnt[DATA_W-1] || (&power_cnt[DATA_W-2:0]);
        end
    end

    always_ff @(posedge i_clk) begin
        case (reg_sel)
            REG_ID:       o_data <= SYS_ID;
            REG_SCRATCH:  o_data <= scratch;
            REG_ERR_ADDR: o_data <= {err_addr, 2'b00};
            REG_POWER:    o_data <= power_cnt;
            REG_IRQ:      o_data <= {{(DATA_W-1){1'b0}}, o_interrupt};
            default:      o_data <= '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/switch_led_port.sv
`default_nettype none

module switch_led_port (
    input  wire logic               i_clk,
    input  wire logic               i_reset,
    input  wire logic               i_stb,
    input  wire logic               i_we,
    input  wire soc_bus_pkg::data_t i_data,
    input  wire logic [15:0]        i_switches,
    output logic                    o_ack,
    output soc_bus_pkg::data_t      o_data,
    output logic [15:0]             o_leds
);

    import soc_bus_pkg::*;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ack  <= 1'b0;
            o_leds <= '0;
        end else begin
            o_ack <= i_stb;
            if (i_stb && i_we) begin
                o_leds <= i_data[15:0];
            end
        end
    end

    // switches read back zero-extended
    always_ff @(posedge i_clk) begin
        o_data <= {{(DATA_W-16){1'b0}}, i_switches};
    end

endmodule

`default_nettype wire

//--- hw/wb_ram.sv
`default_nettype none

module wb_ram #(
    parameter int MEM_AW = 10
) (
    input  wire logic               i_clk,
    input  wire logic               i_stb,
    input  wire logic               i_we,
    input  wire soc_bus_pkg::addr_t i_addr,
    input  wire soc_bus_pkg::data_t i_data,
    input  wire soc_bus_pkg::sel_t  i_sel,
    output logic                    o_ack,
    output soc_bus_pkg::data_t      o_data
);

    import soc_bus_pkg::*;

    localparam int BYTE_W = DATA_W / SEL_W;

    data_t             mem [0:(2**MEM_AW)-1];
    logic [MEM_AW-1:0] ram_idx;

    // upper bits ignored so the RAM repeats across its page
    assign ram_idx = i_addr[MEM_AW-1:0];

    always_ff @(posedge i_clk) begin
        for (int b = 0; b < SEL_W; b++) begin
            if (i_stb && i_we && i_sel[b]) begin
                mem[ram_idx][b*BYTE_W +: BYTE_W] <= i_data[b*BYTE_W +: BYTE_W];
            end
        end
        o_data <= mem[ram_idx];
        o_ack  <= i_stb;
    end

endmodule

`default_nettype wire

//--- hw/soc_bus_top.sv
`default_nettype none

module soc_bus_top #(
    parameter int MEM_AW = 10
) (
    input  wire logic               i_clk,
    input  wire logic               i_reset,
    // cpu-side master
    input  wire logic               i_cpu_cyc,
    input  wire logic               i_cpu_stb,
    input  wire logic               i_cpu_we,
    input  wire soc_bus_pkg::addr_t i_cpu_addr,
    input  wire soc_bus_pkg::data_t i_cpu_data,
    input  wire soc_bus_pkg::sel_t  i_cpu_sel,
    output logic                    o_cpu_ack,
    output logic                    o_cpu_stall,
    output logic                    o_cpu_err,
    // debug master
    input  wire logic               i_dbg_cyc,
    input  wire logic               i_dbg_stb,
    input  wire logic               i_dbg_we,
    input  wire soc_bus_pkg::addr_t i_dbg_addr,
    input  wire soc_bus_pkg::data_t i_dbg_data,
    input  wire soc_bus_pkg::sel_t  i_dbg_sel,
    output logic                    o_dbg_ack,
    output logic                    o_dbg_stall,
    output logic                    o_dbg_err,
    // shared read data
    output soc_bus_pkg::data_t      o_rd_data,
    input  wire logic [15:0]        i_switches,
    output logic [15:0]             o_leds,
    output logic                    o_interrupt
);

    import soc_bus_pkg::*;

    // merged bus
    logic  bus_stb, bus_we, bus_ack, bus_err;
    addr_t bus_addr;
    data_t bus_data;
    sel_t  bus_sel;

    // per-device strobes and responses
    logic  mem_stb, sys_stb, swled_stb;
    logic  mem_ack, sys_ack, swled_ack;
    data_t mem_data, sys_data, swled_data;

    // cpu on port a so it wins on a tie
    wb_pri_arbiter u_arbiter (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_a_cyc(i_cpu_cyc), .i_a_stb(i_cpu_stb), .i_a_we(i_cpu_we),
        .i_a_addr(i_cpu_addr), .i_a_data(i_cpu_data), .i_a_sel(i_cpu_sel),
        .o_a_ack(o_cpu_ack), .o_a_stall(o_cpu_stall), .o_a_err(o_cpu_err),
        .i_b_cyc(i_dbg_cyc), .i_b_stb(i_dbg_stb), .i_b_we(i_dbg_we),
        .i_b_addr(i_dbg_addr), .i_b_data(i_dbg_data), .i_b_sel(i_dbg_sel),
        .o_b_ack(o_dbg_ack), .o_b_stall(o_dbg_stall), .o_b_err(o_dbg_err),
        .o_cyc(), .o_stb(bus_stb), .o_we(bus_we),
        .o_addr(bus_addr), .o_data(bus_data), .o_sel(bus_sel),
        .i_ack(bus_ack), .i_err(bus_err)
    );

    bus_decoder u_decoder (
        .i_clk(i_clk), .i_reset(i_reset), .i_stb(bus_stb), .i_addr(bus_addr),
        .o_mem_stb(mem_stb), .o_sys_stb(sys_stb), .o_swled_stb(swled_stb),
        .i_mem_ack(mem_ack), .i_mem_data(mem_data),
        .i_sys_ack(sys_ack), .i_sys_data(sys_data),
        .i_swled_ack(swled_ack), .i_swled_data(swled_data),
        .o_ack(bus_ack), .o_err(bus_err), .o_data(o_rd_data)
    );

    sys_regs u_sys_regs (
        .i_clk(i_clk), .i_reset(i_reset), .i_stb(sys_stb), .i_we(bus_we),
        .i_addr(bus_addr), .i_data(bus_data), .i_bus_err(bus_err),
        .o_ack(sys_ack), .o_data(sys_data), .o_interrupt(o_interrupt)
    );

    switch_led_port u_swled (
        .i_clk(i_clk), .i_reset(i_reset), .i_stb(swled_stb), .i_we(bus_we),
        .i_data(bus_data), .i_switches(i_switches),
        .o_ack(swled_ack), .o_data(swled_data), .o_leds(o_leds)
    );

    wb_ram #(.MEM_AW(MEM_AW)) u_ram (
        .i_clk(i_clk), .i_stb(mem_stb), .i_we(bus_we), .i_addr(bus_addr),
        .i_data(bus_data), .i_sel(bus_sel), .o_ack(mem_ack), .o_data(mem_data)
    );

endmodule

`default_nettype wire

//--- test/tb_soc_bus.sv
`default_nettype none

module tb_soc_bus;

    timeunit 1ns;
    timeprecision 100ps;

    import soc_bus_pkg::*;

    localparam int MEM_AW = 10;
    localparam int MAX_CYCLES = 200;

    typedef struct packed {
        logic  we;
        logic  cap;
        addr_t addr;
        data_t data;
        sel_t  sel;
    } op_t;

    // due is the negedge count where the response must show
    typedef struct packed {
        int    due;
        logic  is_err;
        logic  chk;
        logic  cap;
        data_t data;
    } resp_t;

    logic        clk;
    logic        reset;
    logic        m_cyc [2];
    logic        m_stb [2];
    logic        m_we [2];
    addr_t       m_addr [2];
    data_t       m_data [2];
    sel_t        m_sel [2];
    logic [15:0] switches;
    wire  [1:0]  ack_w;
    wire  [1:0]  err_w;
    wire  [1:0]  stall_w;
    data_t       rd_data;
    logic [15:0] leds;
    logic        interrupt;

    // reference model
    data_t       ram_model [0:(2**MEM_AW)-1];
    data_t       scratch_model;
    logic        irq_model;
    addr_t       err_model;
    logic [15:0] led_model;
    logic [15:0] sw_model;
    op_t         issue_q [2][$];
    resp_t       resp_q [2][$];
    data_t       power_vals [$];
    int          outstanding [2];
    int          first_ack [2];
    int          last_ack [2];
    int          owner_model;
    int          cycle_no;
    int          data_errs, led_errs, flag_errs, other_errs;
    logic        timed_out;
    string       ack_name [2] = '{"o_cpu_ack", "o_dbg_ack"};
    string       err_name [2] = '{"o_cpu_err", "o_dbg_err"};
    string       stall_name [2] = '{"o_cpu_stall", "o_dbg_stall"};

    soc_bus_top #(.MEM_AW(MEM_AW)) i_dut (
        .i_clk(clk), .i_reset(reset),
        .i_cpu_cyc(m_cyc[0]), .i_cpu_stb(m_stb[0]), .i_cpu_we(m_we[0]),
        .i_cpu_addr(m_addr[0]), .i_cpu_data(m_data[0]), .i_cpu_sel(m_sel[0]),
        .o_cpu_ack(ack_w[0]), .o_cpu_stall(stall_w[0]), .o_cpu_err(err_w[0]),
        .i_dbg_cyc(m_cyc[1]), .i_dbg_stb(m_stb[1]), .i_dbg_we(m_we[1]),
        .i_dbg_addr(m_addr[1]), .i_dbg_data(m_data[1]), .i_dbg_sel(m_sel[1]),
        .o_dbg_ack(ack_w[1]), .o_dbg_stall(stall_w[1]), .o_dbg_err(err_w[1]),
        .o_rd_data(rd_data), .i_switches(switches), .o_leds(leds),
        .o_interrupt(interrupt)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic check_data(string name, data_t got, data_t exp);
        if (got !== exp) begin
            data_errs++;
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_leds(string name, logic [15:0] got, logic [15:0] exp);
        if (got !== exp) begin
            led_errs++;
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            flag_errs++;
            $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    function automatic dev_e decode_dev(addr_t a);
        dev_e dev;
        if (a[ADDR_W-1 -: PAGE_W] == MEM_PAGE) begin
            dev = DEV_MEM;
        end else if (a[ADDR_W-1 -: PAGE_W] == SYS_PAGE) begin
            dev = DEV_SYS;
        end else if (a == SWLED_ADDR) begin
            dev = DEV_SWLED;
        end else begin
            dev = DEV_NONE;
        end
        return dev;
    endfunction

    function automatic addr_t sys_addr(sys_reg_e r);
        return {SYS_PAGE, 17'd0, r};
    endfunction

    // power reads are captured instead of predicted
    function automatic data_t sys_read(addr_t a);
        data_t d;
        case (a[3:0])
            REG_ID:       d = SYS_ID;
            REG_SCRATCH:  d = scratch_model;
            REG_ERR_ADDR: d = {err_model, 2'b00};
            REG_IRQ:      d = {31'd0, irq_model};
            default:      d = '0;
        endcase
        return d;
    endfunction

    // cpu wins an idle bus and the owner keeps it while cyc is high
    function automatic int next_grant();
        int g;
        if (owner_model == 1 && m_cyc[0]) begin
            g = 1;
        end else if (owner_model == 2 && m_cyc[1]) begin
            g = 2;
        end else if (m_cyc[0]) begin
            g = 1;
        end else if (m_cyc[1]) begin
            g = 2;
        end else begin
            g = 0;
        end
        return g;
    endfunction

    function automatic logic bus_idle();
        return issue_q[0].size() == 0 && issue_q[1].size() == 0 && outstanding[0] == 0
            && outstanding[1] == 0 && !m_cyc[0] && !m_cyc[1];
    endfunction

    task automatic queue_request(int m, logic we, addr_t addr, data_t data, sel_t sel,
                                 logic cap);
        op_t op;
        op.we = we;
        op.cap = cap;
        op.addr = addr;
        op.data = data;
        op.sel = sel;
        issue_q[m].push_back(op);
    endtask

    task automatic accept_request(int m);
        op_t               op;
        resp_t             rsp;
        logic [MEM_AW-1:0] idx;
        op = issue_q[m].pop_front();
        outstanding[m]++;
        idx = op.addr[MEM_AW-1:0];
        rsp.is_err = (decode_dev(op.addr) == DEV_NONE);
        rsp.due = cycle_no + (rsp.is_err ? 1 : 2);
        rsp.chk = !op.we && !op.cap;
        rsp.cap = op.cap;
        rsp.data = '0;
        case (decode_dev(op.addr))
            DEV_MEM: begin
                rsp.data = ram_model[idx];
                for (int b = 0; b < SEL_W; b++) begin
                    if (op.we && op.sel[b]) begin
                        ram_model[idx][8*b +: 8] = op.data[8*b +: 8];
                    end
                end
            end
            DEV_SYS: begin
                rsp.data = sys_read(op.addr);
                if (op.we && op.addr[3:0] == REG_SCRATCH) begin
                    scratch_model = op.data;
                end
                if (op.we && op.addr[3:0] == REG_IRQ) begin
                    irq_model = op.data[0];
                end
            end
            DEV_SWLED: begin
                rsp.data = {16'h0000, switches};
                if (op.we) begin
                    led_model = op.data[15:0];
                end
            end
            default: err_model = op.addr;
        endcase
        resp_q[m].push_back(rsp);
    endtask

    task automatic drive_master(int m);
        op_t op;
        if (issue_q[m].size() > 0) begin
            op = issue_q[m][0];
            m_cyc[m] = 1'b1;
            m_stb[m] = 1'b1;
            m_we[m] = op.we;
            m_addr[m] = op.addr;
            m_data[m] = op.data;
            m_sel[m] = op.sel;
        end else begin
            m_stb[m] = 1'b0;
            m_we[m] = 1'b0;
            m_cyc[m] = (outstanding[m] > 0);
        end
    endtask

    // one bus cycle of response checks, request drives and acceptance prediction
    task automatic run_cycle();
        resp_t rsp;
        logic  exp_ack;
        logic  exp_err;
        int    grant;
        @(negedge clk);
        cycle_no++;
        for (int m = 0; m < 2; m++) begin
            exp_ack = 1'b0;
            exp_err = 1'b0;
            if (resp_q[m].size() > 0 && resp_q[m][0].due == cycle_no) begin
                rsp = resp_q[m].pop_front();
                exp_ack = !rsp.is_err;
                exp_err = rsp.is_err;
                outstanding[m]--;
                if (ack_w[m] && rsp.chk) begin
                    check_data("o_rd_data", rd_data, rsp.data);
                end
                if (ack_w[m] && rsp.cap) begin
                    power_vals.push_back(rd_data);
                end
            end
            if (ack_w[m]) begin
                if (first_ack[m] < 0) begin
                    first_ack[m] = cycle_no;
                end
                last_ack[m] = cycle_no;
            end
            check_flag(ack_name[m], ack_w[m], exp_ack);
            check_flag(err_name[m], err_w[m], exp_err);
        end
        if (ack_w == 2'b00) begin
            check_data("o_rd_data", rd_data, '0);
        end
        check_leds("o_leds", leds, led_model);
        check_flag("o_interrupt", interrupt, irq_model);
        switches = sw_model;
        drive_master(0);
        drive_master(1);
        // let the arbiter settle before looking at stall
        #1;
        grant = next_grant();
        for (int m = 0; m < 2; m++) begin
            check_flag(stall_name[m], stall_w[m], m_stb[m] && grant != m + 1);
            if (m_stb[m] && grant == m + 1) begin
                accept_request(m);
            end
        end
        owner_model = grant;
    endtask

    task automatic finish_run();
        $display("errors: data %0d, leds %0d, flags %0d, other %0d",
                 data_errs, led_errs, flag_errs, other_errs);
        if (data_errs + led_errs + flag_errs + other_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    // after a timeout the remaining steps are skipped
    task automatic run_until_idle();
        int n;
        if (timed_out) begin
            return;
        end
        n = 0;
        run_cycle();
        while (!bus_idle() && n < MAX_CYCLES) begin
            run_cycle();
            n++;
        end
        if (!bus_idle()) begin
            other_errs++;
            timed_out = 1'b1;
            $display("timeout at %0t: bus transfers still pending after %0d cycles",
                     $time, MAX_CYCLES);
        end
    endtask

    task automatic run_idle(int n);
        if (!timed_out) begin
            repeat (n) begin
                run_cycle();
            end
        end
    endtask

    initial begin
        int    m;
        addr_t a;
        data_t d;
        void'($urandom(81637));
        reset = 1'b1;
        switches = '0;
        sw_model = '0;
        for (int i = 0; i < 2; i++) begin
            m_cyc[i] = 1'b0;
            m_stb[i] = 1'b0;
            m_we[i] = 1'b0;
            m_addr[i] = '0;
            m_data[i] = '0;
            m_sel[i] = '0;
            outstanding[i] = 0;
        end
        scratch_model = '0;
        irq_model = 1'b0;
        err_model = '0;
        led_model = '0;
        owner_model = 0;
        cycle_no = 0;
        first_ack = '{-1, -1};
        last_ack = '{-1, -1};
        data_errs = 0;
        led_errs = 0;
        flag_errs = 0;
        other_errs = 0;
        timed_out = 1'b0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        // fill a small RAM window and follow with random byte-select writes
        for (int i = 0; i < 16; i++) begin
            queue_request(i / 8, 1'b1, addr_t'(i), $urandom, 4'hF, 1'b0);
        end
        run_until_idle();
        repeat (6) begin
            m = $urandom_range(1, 0);
            repeat (4) begin
                queue_request(m, 1'b1, addr_t'($urandom_range(15, 0)), $urandom,
                              sel_t'($urandom), 1'b0);
            end
            run_until_idle();
        end
        for (int k = 0; k < 2; k++) begin
            for (int i = 0; i < 16; i++) begin
                queue_request(k, 1'b0, addr_t'(i), '0, 4'hF, 1'b0);
            end
            run_until_idle();
        end

        // system registers
        queue_request(0, 1'b0, sys_addr(REG_ID), '0, 4'hF, 1'b0);
        queue_request(0, 1'b1, sys_addr(REG_SCRATCH), $urandom, 4'hF, 1'b0);
        queue_request(0, 1'b0, sys_addr(REG_SCRATCH), '0, 4'hF, 1'b0);
        queue_request(1, 1'b1, sys_addr(REG_IRQ), $urandom | 32'd1, 4'hF, 1'b0);
        queue_request(1, 1'b0, sys_addr(REG_IRQ), '0, 4'hF, 1'b0);
        run_until_idle();
        queue_request(0, 1'b0, sys_addr(REG_POWER), '0, 4'hF, 1'b1);
        run_until_idle();
        run_idle($urandom_range(20, 5));
        queue_request(1, 1'b0, sys_addr(REG_POWER), '0, 4'hF, 1'b1);
        queue_request(1, 1'b1, sys_addr(REG_IRQ), '0, 4'hF, 1'b0);
        run_until_idle();
        if (power_vals.size() != 2 || power_vals[1] <= power_vals[0]) begin
            other_errs++;
            $display("power counter did not increase between two reads");
        end

        // unmapped pages and the unmapped word 0x400000
        for (int i = 0; i < 5; i++) begin
            a = addr_t'($urandom);
            a[ADDR_W-1 -: PAGE_W] = PAGE_W'($urandom_range(511, 3));
            if (i == 4) begin
                a = 30'h400000;
            end
            m = $urandom_range(1, 0);
            queue_request(m, 1'($urandom_range(1, 0)), a, $urandom, 4'hF, 1'b0);
            run_until_idle();
            queue_request(1 - m, 1'b0, sys_addr(REG_ERR_ADDR), '0, 4'hF, 1'b0);
            run_until_idle();
        end

        // switch and LED port
        repeat (4) begin
            m = $urandom_range(1, 0);
            sw_model = 16'($urandom);
            queue_request(m, 1'b1, SWLED_ADDR, $urandom, 4'hF, 1'b0);
            queue_request(m, 1'b0, SWLED_ADDR, '0, 4'hF, 1'b0);
            run_until_idle();
        end

        // both masters start together and debug reads what the cpu wrote
        first_ack = '{-1, -1};
        last_ack = '{-1, -1};
        a = addr_t'($urandom_range(15, 0));
        d = $urandom;
        queue_request(0, 1'b1, a, d, 4'hF, 1'b0);
        queue_request(0, 1'b0, a, '0, 4'hF, 1'b0);
        queue_request(0, 1'b0, sys_addr(REG_SCRATCH), '0, 4'hF, 1'b0);
        queue_request(1, 1'b0, a, '0, 4'hF, 1'b0);
        queue_request(1, 1'b0, SWLED_ADDR, '0, 4'hF, 1'b0);
        run_until_idle();
        if (first_ack[1] <= last_ack[0]) begin
            other_errs++;
            $display("debug master was answered before the cpu master finished its cycle");
        end

        finish_run();
    end

endmodule

`default_nettype wire

//--- sources.f
hw/soc_bus_pkg.sv
hw/wb_pri_arbiter.sv
hw/bus_decoder.sv
hw/sys_regs.sv
hw/switch_led_port.sv
hw/wb_ram.sv
hw/soc_bus_top.sv
test/tb_soc_bus.sv

//--- run_sim.sh
#!/bin/sh
# builds the bus testbench with Verilator and runs it into sim.log
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f sources.f \
    --top-module tb_soc_bus \
    -o tb_soc_bus

./obj_dir/tb_soc_bus > sim.log
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
    exit 0
else
    exit 1
fi
